// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/rv_pkg.sv
logic/rv_bus_if.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_control.sv
logic/rv_core.sv
logic/rv_data_mem.sv
logic/rv_top.sv
tests/rv_clk_gen.sv
tests/rv_assertions.sv
tests/rv_tb.sv

// File: logic/rv_alu.sv
module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   y,
    output logic            eq,
    output logic            lt
);

    // Branch compare, signed
    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:    y = a + b;
            rv_pkg::ALU_SUB:    y = a - b;
            rv_pkg::ALU_AND:    y = a & b;
            rv_pkg::ALU_OR:     y = a | b;
            rv_pkg::ALU_XOR:    y = a ^ b;
            rv_pkg::ALU_SLT:    y = {31'd0, lt};
            rv_pkg::ALU_PASS_B: y = b;
            default:            y = a + b;
        endcase
    end

endmodule

// File: logic/rv_bus_if.sv
interface rv_bus_if;

    rv_pkg::word_t addr;
    rv_pkg::word_t wdata;
    logic [3:0]    be;
    logic          valid;
    // Valid one cycle after the request
    rv_pkg::word_t rdata;

    modport core (output addr, output wdata, output be, output valid, input rdata);

    modport mem (input addr, input wdata, input be, input valid, output rdata);

endinterface

// File: logic/rv_control.sv
module rv_control (
    input  rv_pkg::word_t   inst_dec,
    input  logic [4:0]      rd_exe,
    input  logic [4:0]      rd_mem,
    input  logic            rd_we_exe,
    input  logic            rd_we_mem,
    input  logic            br_eq,
    input  logic            br_lt,
    input  logic            branch_exe,
    input  logic            jump_exe,
    input  logic            beq_exe,
    output rv_pkg::alu_op_t alu_op,
    output logic            b_sel,
    output logic            a_sel,
    output rv_pkg::wb_sel_t wb_sel,
    output logic            rd_we,
    output logic            mem_read,
    output logic            mem_write,
    output logic [2:0]      mem_width,
    output logic [1:0]      branch_type,
    output logic            jump,
    output logic            fwd_a,
    output logic            fwd_b,
    output rv_pkg::pc_sel_t pc_sel,
    output logic            flush
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            taken;
    logic            unused_inputs;

    assign opcode = rv_pkg::opcode_t'(inst_dec[6:0]);
    assign funct3 = inst_dec[14:12];
    assign rs1 = inst_dec[19:15];
    assign rs2 = inst_dec[24:20];

    // ------------------------------
    // Decode
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        b_sel = 1'b0;
        a_sel = 1'b0;
        wb_sel = rv_pkg::WB_ALU;
        rd_we = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        branch_type = 2'b00;
        jump = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                rd_we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = inst_dec[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    3'b111:  alu_op = rv_pkg::ALU_AND;
                    default: alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                b_sel = 1'b1;
                rd_we = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                // a is ignored under PASS_B
                alu_op = rv_pkg::ALU_PASS_B;
                a_sel = 1'b1;
                b_sel = 1'b1;
                rd_we = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                b_sel = 1'b1;
                rd_we = 1'b1;
                mem_read = 1'b1;
                wb_sel = rv_pkg::WB_LOAD;
            end
            rv_pkg::OPC_STORE: begin
                b_sel = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                // Type bit 0 set for BEQ
                alu_op = rv_pkg::ALU_SUB;
                branch_type = {1'b1, funct3 == 3'b000};
            end
            rv_pkg::OPC_JAL: begin
                // Target from the ALU, link from PC + 4
                a_sel = 1'b1;
                b_sel = 1'b1;
                rd_we = 1'b1;
                jump = 1'b1;
                wb_sel = rv_pkg::WB_PC_INC4;
            end
            default: ;
        endcase
    end

    assign mem_width = funct3;

    // ------------------------------
    // Forwarding
    // The instruction now in EXE sits in MEM when this one reaches EXE
    assign fwd_a = rd_we_exe && (rd_exe != 5'd0) && (rs1 == rd_exe);
    assign fwd_b = rd_we_exe && (rd_exe != 5'd0) && (rs2 == rd_exe);

    // MEM writes reach DEC through the register-file bypass
    // BLT is not in the subset
    assign unused_inputs = ^{br_lt, rd_mem, rd_we_mem};

    // ------------------------------
    // Redirect
    assign taken = branch_exe && (beq_exe ? br_eq : !br_eq);
    assign flush = taken || jump_exe;
    assign pc_sel = flush ? rv_pkg::PC_TARGET : rv_pkg::PC_INC4;

endmodule

// File: logic/rv_core.sv
module rv_core #(
    parameter int IMEM_WORDS = 256
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          imem_we,
    input  logic [7:0]    imem_waddr,
    input  rv_pkg::word_t imem_wdata,
    rv_bus_if.core        dbus
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    rv_pkg::word_t   imem [IMEM_WORDS];
    rv_pkg::word_t   pc_fet;
    rv_pkg::word_t   pc_next;
    rv_pkg::word_t   target_exe;
    rv_pkg::pc_sel_t pc_sel;
    logic            flush;
    rv_pkg::word_t   wb_data;

    // ------------------------------
    // Fetch
    rv_pkg::word_t imem_q;
    rv_pkg::word_t pc_dec;
    logic          dec_kill;

    assign pc_next = (pc_sel == rv_pkg::PC_TARGET) ? target_exe : pc_fet + 32'd4;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
        imem_q <= imem[pc_fet[IMEM_AW+1:2]];
        pc_dec <= pc_fet;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_fet <= '0;
            dec_kill <= 1'b1;
        end else begin
            pc_fet <= pc_next;
            dec_kill <= flush;
        end
    end

    // ------------------------------
    // Decode
    rv_pkg::word_t   inst_dec;
    rv_pkg::opcode_t opcode_dec;
    rv_pkg::word_t   imm_dec;
    rv_pkg::word_t   rs1_dec;
    rv_pkg::word_t   rs2_dec;
    rv_pkg::alu_op_t alu_op_dec;
    rv_pkg::wb_sel_t wb_sel_dec;
    logic            a_sel_dec;
    logic            b_sel_dec;
    logic            rd_we_dec;
    logic            mem_read_dec;
    logic            mem_write_dec;
    logic [2:0]      mem_width_dec;
    logic [1:0]      branch_type_dec;
    logic            jump_dec;
    logic            fwd_a_dec;
    logic            fwd_b_dec;

    // Killed fetch shows up as a NOP
    assign inst_dec = dec_kill ? rv_pkg::NOP : imem_q;
    assign opcode_dec = rv_pkg::opcode_t'(inst_dec[6:0]);

    always_comb begin
        case (opcode_dec)
            rv_pkg::OPC_STORE:
                imm_dec = {{20{inst_dec[31]}}, inst_dec[31:25], inst_dec[11:7]};
            rv_pkg::OPC_BRANCH:
                imm_dec = {{19{inst_dec[31]}}, inst_dec[31], inst_dec[7],
                           inst_dec[30:25], inst_dec[11:8], 1'b0};
            rv_pkg::OPC_JAL:
                imm_dec = {{11{inst_dec[31]}}, inst_dec[31], inst_dec[19:12],
                           inst_dec[20], inst_dec[30:21], 1'b0};
            rv_pkg::OPC_LUI:
                imm_dec = {inst_dec[31:12], 12'd0};
            default:
                imm_dec = {{20{inst_dec[31]}}, inst_dec[31:20]};
        endcase
    end

    // EXE/MEM side, declared early for control and register file
    rv_pkg::word_t inst_exe;
    logic [4:0]    rd_exe;
    logic          rd_we_exe;
    logic          branch_exe;
    logic          jump_exe;
    logic          beq_exe;
    logic          br_eq;
    logic          br_lt;
    logic [4:0]    rd_mem;
    logic          rd_we_mem;

    assign rd_exe = inst_exe[11:7];

    rv_control rv_control_i (
        .inst_dec    (inst_dec),
        .rd_exe      (rd_exe),
        .rd_mem      (rd_mem),
        .rd_we_exe   (rd_we_exe),
        .rd_we_mem   (rd_we_mem),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .branch_exe  (branch_exe),
        .jump_exe    (jump_exe),
        .beq_exe     (beq_exe),
        .alu_op      (alu_op_dec),
        .b_sel       (b_sel_dec),
        .a_sel       (a_sel_dec),
        .wb_sel      (wb_sel_dec),
        .rd_we       (rd_we_dec),
        .mem_read    (mem_read_dec),
        .mem_write   (mem_write_dec),
        .mem_width   (mem_width_dec),
        .branch_type (branch_type_dec),
        .jump        (jump_dec),
        .fwd_a       (fwd_a_dec),
        .fwd_b       (fwd_b_dec),
        .pc_sel      (pc_sel),
        .flush       (flush)
    );

    rv_reg_file rv_reg_file_i (
        .clk    (clk),
        .we     (rd_we_mem),
        .addr_a (inst_dec[19:15]),
        .addr_b (inst_dec[24:20]),
        .addr_d (rd_mem),
        .data_d (wb_data),
        .data_a (rs1_dec),
        .data_b (rs2_dec)
    );

    // ------------------------------
    // DEC/EXE
    rv_pkg::word_t   pc_exe;
    rv_pkg::word_t   rs1_exe;
    rv_pkg::word_t   rs2_exe;
    rv_pkg::word_t   imm_exe;
    rv_pkg::alu_op_t alu_op_exe;
    rv_pkg::wb_sel_t wb_sel_exe;
    logic            a_sel_exe;
    logic            b_sel_exe;
    logic            mem_read_exe;
    logic            mem_write_exe;
    logic [2:0]      mem_width_exe;
    logic            fwd_a_exe;
    logic            fwd_b_exe;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            inst_exe <= rv_pkg::NOP;
            rd_we_exe <= 1'b0;
            mem_read_exe <= 1'b0;
            mem_write_exe <= 1'b0;
            branch_exe <= 1'b0;
            jump_exe <= 1'b0;
            fwd_a_exe <= 1'b0;
            fwd_b_exe <= 1'b0;
        end else begin
            inst_exe <= inst_dec;
            rd_we_exe <= rd_we_dec;
            mem_read_exe <= mem_read_dec;
            mem_write_exe <= mem_write_dec;
            branch_exe <= branch_type_dec[1];
            jump_exe <= jump_dec;
            fwd_a_exe <= fwd_a_dec;
            fwd_b_exe <= fwd_b_dec;
        end
    end

    always_ff @(posedge clk) begin
        pc_exe <= pc_dec;
        rs1_exe <= rs1_dec;
        rs2_exe <= rs2_dec;
        imm_exe <= imm_dec;
        alu_op_exe <= alu_op_dec;
        wb_sel_exe <= wb_sel_dec;
        a_sel_exe <= a_sel_dec;
        b_sel_exe <= b_sel_dec;
        mem_width_exe <= mem_width_dec;
        beq_exe <= branch_type_dec[0];
    end

    // ------------------------------
    // Execute
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_y;
    logic          byte_exe;

    assign op_a = fwd_a_exe ? wb_data : rs1_exe;
    assign op_b = fwd_b_exe ? wb_data : rs2_exe;

    rv_alu rv_alu_i (
        .op (alu_op_exe),
        .a  (a_sel_exe ? pc_exe : op_a),
        .b  (b_sel_exe ? imm_exe : op_b),
        .y  (alu_y),
        .eq (br_eq),
        .lt (br_lt)
    );

    // The ALU is busy comparing for branches, so they get their own adder
    assign target_exe = branch_exe ? pc_exe + imm_exe : alu_y;

    // Data bus, store data lane-aligned
    assign byte_exe = (mem_width_exe[1:0] == 2'b00);
    assign dbus.addr = alu_y;
    assign dbus.valid = mem_read_exe || mem_write_exe;
    assign dbus.wdata = op_b << {alu_y[1:0], 3'b000};
    assign dbus.be = !mem_write_exe ? 4'b0000 :
                     byte_exe       ? 4'b0001 << alu_y[1:0] : 4'b1111;

    // ------------------------------
    // EXE/MEM
    rv_pkg::word_t   alu_mem;
    rv_pkg::word_t   pc_inc4_mem;
    rv_pkg::wb_sel_t wb_sel_mem;
    logic [2:0]      mem_width_mem;
    logic [1:0]      ofs_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_we_mem <= 1'b0;
            rd_mem <= 5'd0;
        end else begin
            rd_we_mem <= rd_we_exe;
            rd_mem <= rd_exe;
        end
    end

    always_ff @(posedge clk) begin
        alu_mem <= alu_y;
        pc_inc4_mem <= pc_exe + 32'd4;
        wb_sel_mem <= wb_sel_exe;
        mem_width_mem <= mem_width_exe;
        ofs_mem <= alu_y[1:0];
    end

    // ------------------------------
    // Memory and writeback
    rv_pkg::word_t load_word;
    rv_pkg::word_t load_data;

    assign load_word = dbus.rdata >> {ofs_mem, 3'b000};

    always_comb begin
        if (mem_width_mem[1:0] == 2'b10) begin
            load_data = load_word;
        end else if (mem_width_mem[2]) begin
            load_data = {24'd0, load_word[7:0]};
        end else begin
            load_data = {{24{load_word[7]}}, load_word[7:0]};
        end
    end

    always_comb begin
        case (wb_sel_mem)
            rv_pkg::WB_LOAD:    wb_data = load_data;
            rv_pkg::WB_PC_INC4: wb_data = pc_inc4_mem;
            default:            wb_data = alu_mem;
        endcase
    end

endmodule

// File: logic/rv_data_mem.sv
module rv_data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic          clk,
    input  logic          rst,
    rv_bus_if.mem         bus,
    output logic          tohost_valid,
    output rv_pkg::word_t tohost_data
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    rv_pkg::word_t      ram [DMEM_WORDS];
    rv_pkg::word_t      ram_q;
    logic [DMEM_AW-1:0] idx;
    logic               ram_sel;
    logic               io_sel;
    logic               io_q;
    logic               tohost_hit;

    assign idx = bus.addr[DMEM_AW+1:2];
    assign ram_sel = bus.valid && (bus.addr[31:30] == rv_pkg::DMEM_RANGE);
    assign io_sel = bus.valid && (bus.addr[31:30] == rv_pkg::MMIO_RANGE);
    assign tohost_hit = io_sel && (|bus.be) && (bus.addr[29:2] == rv_pkg::TOHOST_ADDR);

    // Byte-enabled write, synchronous read
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_sel && bus.be[i]) begin
                ram[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
        if (ram_sel) begin
            ram_q <= ram[idx];
        end
    end

    // ------------------------------
    // I/O
    always_ff @(posedge clk) begin
        if (rst) begin
            tohost_valid <= 1'b0;
            tohost_data <= '0;
            io_q <= 1'b0;
        end else begin
            tohost_valid <= tohost_hit;
            io_q <= io_sel;
            if (tohost_hit) begin
                tohost_data <= bus.wdata;
            end
        end
    end

    assign bus.rdata = io_q ? tohost_data : ram_q;

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;

    // RV32I major opcodes in the subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC_INC4} wb_sel_t;

    typedef enum logic {PC_INC4, PC_TARGET} pc_sel_t;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    // Address bits 31:30
    localparam logic [1:0] DMEM_RANGE = 2'b00;
    localparam logic [1:0] MMIO_RANGE = 2'b10;
    localparam logic [27:0] TOHOST_ADDR = 28'd0;

endpackage

// File: logic/rv_reg_file.sv
module rv_reg_file (
    input  logic          clk,
    input  logic          we,
    input  logic [4:0]    addr_a,
    input  logic [4:0]    addr_b,
    input  logic [4:0]    addr_d,
    input  rv_pkg::word_t data_d,
    output rv_pkg::word_t data_a,
    output rv_pkg::word_t data_b
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && addr_d != 5'd0) begin
            regs[addr_d] <= data_d;
        end
    end

    // Same-cycle write from MEM is bypassed to the read ports
    assign data_a = (addr_a == 5'd0) ? '0 : (we && addr_a == addr_d) ? data_d : regs[addr_a];
    assign data_b = (addr_b == 5'd0) ? '0 : (we && addr_b == addr_d) ? data_d : regs[addr_b];

endmodule

// File: logic/rv_top.sv
module rv_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          imem_we,
    input  logic [7:0]    imem_waddr,
    input  rv_pkg::word_t imem_wdata,
    output logic          tohost_valid,
    output rv_pkg::word_t tohost_data
);

    rv_bus_if dbus ();

    rv_core #(
        .IMEM_WORDS (IMEM_WORDS)
    ) rv_core_i (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .dbus       (dbus.core)
    );

    rv_data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) rv_data_mem_i (
        .clk          (clk),
        .rst          (rst),
        .bus          (dbus.mem),
        .tohost_valid (tohost_valid),
        .tohost_data  (tohost_data)
    );

endmodule

// File: tests/rv_assertions.sv
module rv_assertions (
    input logic          clk,
    input logic          rst,
    input logic          flush,
    input rv_pkg::word_t inst_exe,
    input logic          bus_valid,
    input logic [3:0]    bus_be,
    input rv_pkg::word_t bus_addr
);

    timeunit 1ns;
    timeprecision 100ps;

    logic tohost_req;
    int   fail_count = 0;

    // Store into the I/O range while in EXE
    assign tohost_req = bus_valid && (|bus_be) && (bus_addr[31:30] == rv_pkg::MMIO_RANGE);

    // Strobe can never be high two cycles running
    tohost_gap: assert property (@(posedge clk) disable iff (rst) tohost_req |=> !tohost_req)
        else begin
            fail_count++;
            $error("tohost store requested in two consecutive cycles");
        end

    // Both instructions behind a redirect are killed
    flush_nop: assert property (@(posedge clk) disable iff (rst)
        flush |=> (inst_exe == rv_pkg::NOP) ##1 (inst_exe == rv_pkg::NOP))
        else begin
            fail_count++;
            $error("instruction in EXE after flush is not a NOP");
        end

    // Only a store in EXE may drive byte enables
    idle_be: assert property (@(posedge clk) disable iff (rst)
        (inst_exe[6:0] != rv_pkg::OPC_STORE) |-> (bus_be == 4'b0000))
        else begin
            fail_count++;
            $error("byte enables active without a store in EXE");
        end

endmodule

// File: tests/rv_clk_gen.sv
module rv_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

// File: tests/rv_tb.sv
module rv_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Instruction counts of all programs, used by the watchdog
    localparam int PROG_INSTRS = 3 * 18 + 23 + 14 + 9 + 8;
    localparam int RUNS = 7;
    localparam int WATCHDOG_CYCLES = PROG_INSTRS * 4 + RUNS * 40 + 100;

    logic          clk;
    logic          rst;
    logic          imem_we;
    logic [7:0]    imem_waddr;
    rv_pkg::word_t imem_wdata;
    logic          tohost_valid;
    rv_pkg::word_t tohost_data;

    rv_pkg::word_t prog [$];
    rv_pkg::word_t got [$];
    logic          rst_seen;
    integer        seed;

    rv_clk_gen rv_clk_gen_i (.clk(clk));

    rv_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata),
        .tohost_valid (tohost_valid),
        .tohost_data  (tohost_data)
    );

    bind rv_core rv_assertions rv_assertions_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .inst_exe  (inst_exe),
        .bus_valid (dbus.valid),
        .bus_be    (dbus.be),
        .bus_addr  (dbus.addr)
    );

    // ------------------------------
    // Reporting and compares
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t act,
                                input rv_pkg::word_t exp);
        if (act !== exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic compare_count(input string name, input int act, input int exp);
        if (act != exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    // ------------------------------
    // Instruction encoders
    function automatic rv_pkg::word_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'(rv_pkg::OPC_OP)};
    endfunction

    function automatic rv_pkg::word_t encode_i(input int imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input rv_pkg::opcode_t opc);
        logic [11:0] i12;
        i12 = imm[11:0];
        return {i12, rs1, f3, rd, 7'(opc)};
    endfunction

    function automatic rv_pkg::word_t encode_s(input int imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        logic [11:0] i12;
        i12 = imm[11:0];
        return {i12[11:5], rs2, rs1, f3, i12[4:0], 7'(rv_pkg::OPC_STORE)};
    endfunction

    function automatic rv_pkg::word_t encode_b(input int imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] i13;
        i13 = imm[12:0];
        return {i13[12], i13[10:5], rs2, rs1, f3, i13[4:1], i13[11], 7'(rv_pkg::OPC_BRANCH)};
    endfunction

    function automatic rv_pkg::word_t encode_j(input int imm, input logic [4:0] rd);
        logic [20:0] i21;
        i21 = imm[20:0];
        return {i21[20], i21[10:1], i21[11], i21[19:12], rd, 7'(rv_pkg::OPC_JAL)};
    endfunction

    function automatic rv_pkg::word_t encode_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'(rv_pkg::OPC_LUI)};
    endfunction

    // Store a register to tohost through x31
    function automatic rv_pkg::word_t store_tohost(input logic [4:0] rs);
        return encode_s(0, rs, 5'd31, 3'b010);
    endfunction

    task automatic push_const(input logic [4:0] rd, input rv_pkg::word_t value);
        rv_pkg::word_t hi;
        hi = (value + 32'h800) >> 12;
        prog.push_back(encode_lui(hi[19:0], rd));
        prog.push_back(encode_i(int'(value[11:0]), rd, 3'b000, rd, rv_pkg::OPC_OP_IMM));
    endtask

    // ------------------------------
    // Program loading and strobe capture
    always @(posedge clk) begin
        rst_seen <= rst;
    end

    always @(negedge clk) begin
        if (tohost_valid && rst_seen) begin
            fail_run("tohost strobe seen while reset was asserted");
        end else if (tohost_valid) begin
            got.push_back(tohost_data);
        end
    end

    task automatic load_program();
        @(negedge clk);
        rst = 1'b1;
        foreach (prog[i]) begin
            @(negedge clk);
            imem_we = 1'b1;
            imem_waddr = 8'(i);
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        got.delete();
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_program(input int n);
        load_program();
        while (got.size() < n) begin
            @(negedge clk);
        end
        // Give skipped stores time to show up
        repeat (20) @(negedge clk);
        compare_count("strobe_count", got.size(), n);
    endtask

    // ------------------------------
    // Tests
    task automatic alu_chain_test();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t exp [6];
        a = $random(seed);
        b = $random(seed);
        prog.delete();
        prog.push_back(encode_lui(20'h80000, 5'd31));
        push_const(5'd1, a);
        push_const(5'd2, b);
        prog.push_back(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(store_tohost(5'd3));
        prog.push_back(encode_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        prog.push_back(store_tohost(5'd4));
        prog.push_back(encode_r(7'h00, 5'd1, 5'd4, 3'b111, 5'd5));
        prog.push_back(store_tohost(5'd5));
        prog.push_back(encode_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
        prog.push_back(store_tohost(5'd6));
        prog.push_back(encode_r(7'h00, 5'd1, 5'd6, 3'b100, 5'd7));
        prog.push_back(store_tohost(5'd7));
        prog.push_back(encode_r(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));
        prog.push_back(store_tohost(5'd8));
        prog.push_back(encode_j(0, 5'd0));
        exp[0] = a + b;
        exp[1] = exp[0] - a;
        exp[2] = exp[1] & a;
        exp[3] = exp[2] | b;
        exp[4] = exp[3] ^ a;
        exp[5] = ($signed(exp[4]) < $signed(a)) ? 32'd1 : 32'd0;
        run_program(6);
        foreach (exp[i]) begin
            compare_word($sformatf("alu_result[%0d]", i), got[i], exp[i]);
        end
    endtask

    task automatic load_test();
        rv_pkg::word_t w;
        rv_pkg::word_t exp [9];
        logic [7:0]    by;
        w = $random(seed);
        w[7] = 1'b1;
        w[15] = 1'b0;
        prog.delete();
        prog.push_back(encode_lui(20'h80000, 5'd31));
        push_const(5'd1, w);
        prog.push_back(encode_s(64, 5'd1, 5'd0, 3'b010));
        prog.push_back(encode_i(64, 5'd0, 3'b010, 5'd2, rv_pkg::OPC_LOAD));
        prog.push_back(store_tohost(5'd2));
        exp[0] = w;
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encode_i(64 + k, 5'd0, 3'b000, 5'd3, rv_pkg::OPC_LOAD));
            prog.push_back(store_tohost(5'd3));
            by = w[8*k +: 8];
            exp[1 + k] = {{24{by[7]}}, by};
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encode_i(64 + k, 5'd0, 3'b100, 5'd4, rv_pkg::OPC_LOAD));
            prog.push_back(store_tohost(5'd4));
            exp[5 + k] = {24'd0, w[8*k +: 8]};
        end
        prog.push_back(encode_j(0, 5'd0));
        run_program(9);
        foreach (exp[i]) begin
            compare_word($sformatf("load_value[%0d]", i), got[i], exp[i]);
        end
    endtask

    task automatic branch_test();
        rv_pkg::word_t v;
        v = $random(seed) & 32'h3ff;
        prog.delete();
        prog.push_back(encode_lui(20'h80000, 5'd31));
        prog.push_back(encode_i(int'(v), 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
        prog.push_back(encode_i(int'(v), 5'd0, 3'b000, 5'd2, rv_pkg::OPC_OP_IMM));
        prog.push_back(encode_i(int'(v) + 1, 5'd0, 3'b000, 5'd3, rv_pkg::OPC_OP_IMM));
        // Taken BEQ skips a store
        prog.push_back(encode_b(8, 5'd2, 5'd1, 3'b000));
        prog.push_back(store_tohost(5'd3));
        prog.push_back(store_tohost(5'd1));
        prog.push_back(encode_b(8, 5'd2, 5'd1, 3'b001));
        prog.push_back(store_tohost(5'd3));
        // Taken BNE skips a register write
        prog.push_back(encode_b(8, 5'd3, 5'd1, 3'b001));
        prog.push_back(encode_i(99, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
        prog.push_back(encode_b(8, 5'd3, 5'd1, 3'b000));
        prog.push_back(store_tohost(5'd1));
        prog.push_back(encode_j(0, 5'd0));
        run_program(3);
        compare_word("branch_store[0]", got[0], v);
        compare_word("branch_store[1]", got[1], v + 32'd1);
        compare_word("branch_store[2]", got[2], v);
    endtask

    task automatic jal_test();
        prog.delete();
        prog.push_back(encode_lui(20'h80000, 5'd31));
        prog.push_back(encode_j(12, 5'd5));
        prog.push_back(encode_i(1, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
        prog.push_back(store_tohost(5'd5));
        prog.push_back(store_tohost(5'd5));
        prog.push_back(encode_j(8, 5'd6));
        prog.push_back(encode_i(3, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));
        prog.push_back(store_tohost(5'd6));
        prog.push_back(encode_j(0, 5'd0));
        run_program(2);
        // Link is the JAL address plus 4
        compare_word("jal_link[0]", got[0], 32'd4 + 32'd4);
        compare_word("jal_link[1]", got[1], 32'd20 + 32'd4);
    endtask

    task automatic reset_test();
        int strobes;
        strobes = 0;
        prog.delete();
        prog.push_back(encode_lui(20'h80000, 5'd31));
        prog.push_back(encode_i(1, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
        prog.push_back(store_tohost(5'd1));
        prog.push_back(encode_i(1, 5'd1, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
        prog.push_back(store_tohost(5'd1));
        prog.push_back(encode_i(1, 5'd1, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
        prog.push_back(store_tohost(5'd1));
        prog.push_back(encode_j(-16, 5'd0));
        load_program();
        while (strobes < 2) begin
            @(negedge clk);
            if (tohost_valid) begin
                strobes++;
            end
        end
        // Third store is in EXE now
        @(negedge clk);
        rst = 1'b1;
        compare_count("pre_reset_count", got.size(), 2);
        compare_word("pre_reset_store[0]", got[0], 32'd1);
        compare_word("pre_reset_store[1]", got[1], 32'd2);
        @(negedge clk);
        compare_word("tohost_data", tohost_data, 32'd0);
        got.delete();
        @(negedge clk);
        rst = 1'b0;
        while (got.size() < 2) begin
            @(negedge clk);
        end
        compare_word("restart_store[0]", got[0], 32'd1);
        compare_word("restart_store[1]", got[1], 32'd2);
    endtask

    // ------------------------------
    // Watchdog and main sequence
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("timeout waiting for tohost strobes");
    end

    initial begin
        seed = 66664;
        rst = 1'b1;
        imem_we = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        repeat (2) @(negedge clk);
        repeat (3) alu_chain_test();
        load_test();
        branch_test();
        jal_test();
        reset_test();
        if (i_dut.rv_core_i.rv_assertions_i.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("a concurrent assertion on the core failed");
        end
    end

endmodule
